// File: verilog/instrBuffer_macros.svh
// Instruction width, bank depth, bank address width and bank count macros

`ifndef INSTR_BUFFER_MACROS_SVH
`define INSTR_BUFFER_MACROS_SVH

//////////////////////////////////////////////////
// Instruction word
//////////////////////////////////////////////////
`define INSTR_WIDTH 32

//////////////////////////////////////////////////
// Memory geometry
//////////////////////////////////////////////////
`define IMEM_DEPTH 1024          // Words per bank
`define IMEM_ADDRESS_WIDTH 10    // log2 of IMEM_DEPTH
`define IMEM_BANK_COUNT 2        // Double buffer

`endif

// File: verilog/instrBufferPkg.sv
// Package with instruction, address, bank and occupancy types and the controller state enums
`default_nettype none

`include "instrBuffer_macros.svh"

package instrBufferPkg;

	// Payload and addressing
	typedef logic [`INSTR_WIDTH-1:0] instr_t;
	typedef logic [`IMEM_ADDRESS_WIDTH-1:0] instrAddress_t;

	// Bank ring bookkeeping
	typedef logic [0:0] bankIndex_t;
	typedef logic [1:0] occupancy_t;    // 0 to 2 committed banks

	// Store side FSM
	typedef enum logic {
		storeIdle,      // Nothing written since last commit
		storeFilling    // At least one word in the bank
	} storeState_t;

	// Fetch side FSM
	typedef enum logic {
		fetchIdle,      // No fetch from current bank yet
		fetchReading    // Bank has been read at least once
	} fetchState_t;

endpackage

`default_nettype wire

// File: verilog/memPorts.sv
// Memory write port and memory read port interfaces
`default_nettype none
`timescale 1ns/100ps

//////////////////////////////////////////////////
// Write side
//////////////////////////////////////////////////
interface memWritePort;
	import instrBufferPkg::*;

	logic enable;
	bankIndex_t bank;
	instrAddress_t address;
	instr_t data;

	// Store controller drives everything
	modport source (output enable, output bank, output address, output data);

	// Memory takes the word at the edge where enable is high
	modport sink (input enable, input bank, input address, input data);

endinterface

//////////////////////////////////////////////////
// Read side
//////////////////////////////////////////////////
interface memReadPort;
	import instrBufferPkg::*;

	logic enable;
	bankIndex_t bank;
	instrAddress_t address;
	instr_t data;    // Valid one clock after enable

	// Fetch controller issues the request
	modport source (output enable, output bank, output address, input data);

	// Memory returns the registered word
	modport sink (input enable, input bank, input address, output data);

endinterface

`default_nettype wire

// File: verilog/bankRing.sv
// Two-bank ring control with write pointer, read pointer and occupancy
`default_nettype none
`timescale 1ns/100ps

module bankRing (
	input wire logic clock,
	input wire logic reset,
	input wire logic commit,         // Store side finished a bank
	input wire logic bankRelease,    // Fetch side done with a bank
	output instrBufferPkg::bankIndex_t writeBank,
	output instrBufferPkg::bankIndex_t readBank,
	output logic empty,
	output logic full
);
	import instrBufferPkg::*;

	bankIndex_t writePointer;
	bankIndex_t readPointer;
	occupancy_t occupancy;
	logic commitTaken;
	logic releaseTaken;

	// Guard against pulses that make no sense for the current count
	assign commitTaken = commit && (occupancy != 2'd2);
	assign releaseTaken = bankRelease && (occupancy != 2'd0);

	//////////////////////////////////////////////////
	// Pointers and count
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			writePointer <= '0;
			readPointer <= '0;
			occupancy <= '0;
		end else begin
			if (commitTaken) begin
				writePointer <= ~writePointer;
			end
			if (releaseTaken) begin
				readPointer <= ~readPointer;
			end

			// Commit and release together leave the count alone
			case ({commitTaken, releaseTaken})
				2'b10: occupancy <= occupancy + 2'd1;
				2'b01: occupancy <= occupancy - 2'd1;
				default: occupancy <= occupancy;
			endcase
		end
	end

	assign writeBank = writePointer;
	assign readBank = readPointer;

	// Decoded from the registered count, so one cycle behind the pulse
	assign empty = (occupancy == 2'd0);
	assign full = (occupancy == 2'd2);

endmodule

`default_nettype wire

// File: verilog/storeControl.sv
// Store controller that gates host writes, counts the write address and commits banks
`default_nettype none
`timescale 1ns/100ps

module storeControl (
	input wire logic clock,
	input wire logic reset,
	input wire logic storeRequest,
	input wire logic storeEnd,
	input wire instrBufferPkg::instr_t storeInstr,
	input wire instrBufferPkg::bankIndex_t writeBank,
	input wire logic full,
	output logic commit,
	memWritePort.source writePort
);
	import instrBufferPkg::*;

	storeState_t state;
	instrAddress_t storeAddress;
	logic writeEnable;

	// Full is the only back-pressure
	assign writeEnable = storeRequest && !full;

	// End pulse only counts once something was written
	assign commit = storeEnd && (state == storeFilling);

	//////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////
	assign writePort.enable = writeEnable;
	assign writePort.bank = writeBank;
	assign writePort.address = storeAddress;
	assign writePort.data = storeInstr;

	always_ff @(posedge clock) begin
		if (reset) begin
			storeAddress <= '0;
		end else if (commit) begin
			storeAddress <= '0;    // Next program starts at word zero
		end else if (writeEnable) begin
			storeAddress <= storeAddress + 1'b1;
		end
	end

	// Filling state machine
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= storeIdle;
		end else begin
			case (state)
				storeIdle: if (writeEnable) state <= storeFilling;
				storeFilling: if (storeEnd) state <= storeIdle;
				default: state <= storeIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/fetchControl.sv
// Fetch controller that gates lane reads, releases banks and flags returned data
`default_nettype none
`timescale 1ns/100ps

module fetchControl (
	input wire logic clock,
	input wire logic reset,
	input wire logic fetchRequest,
	input wire instrBufferPkg::instrAddress_t fetchAddress,
	input wire logic fetchEnd,
	input wire instrBufferPkg::bankIndex_t readBank,
	input wire logic empty,
	output logic bankRelease,
	output logic fetchValid,
	memReadPort.source readPort
);
	import instrBufferPkg::*;

	fetchState_t state;
	logic readEnable;

	// Nothing to read without a committed bank
	assign readEnable = fetchRequest && !empty;

	// Release only after the bank was actually used
	assign bankRelease = fetchEnd && (state == fetchReading);

	//////////////////////////////////////////////////
	// Read port
	//////////////////////////////////////////////////
	assign readPort.enable = readEnable;
	assign readPort.bank = readBank;    // Old bank still selected on the release edge
	assign readPort.address = fetchAddress;

	// Data comes back from the memory register one clock later
	always_ff @(posedge clock) begin
		if (reset) begin
			fetchValid <= 1'b0;
		end else begin
			fetchValid <= readEnable;
		end
	end

	//////////////////////////////////////////////////
	// Reading state machine
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fetchIdle;
		end else begin
			case (state)
				fetchIdle: begin
					if (readEnable) begin
						state <= fetchReading;
					end
				end
				fetchReading: begin
					if (fetchEnd) begin
						state <= fetchIdle;    // Bank handed back to the ring
					end
				end
				default: state <= fetchIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/bankStore.sv
// Two instruction memory banks with one write port and one registered read port
`default_nettype none
`timescale 1ns/100ps

`include "instrBuffer_macros.svh"

module bankStore (
	input wire logic clock,
	memWritePort.sink writePort,
	memReadPort.sink readPort,
	output instrBufferPkg::instr_t fetchInstr
);
	import instrBufferPkg::*;

	// Bank index is the outer dimension
	instr_t memory [`IMEM_BANK_COUNT][`IMEM_DEPTH];
	instr_t readData;

	//////////////////////////////////////////////////
	// Write
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (writePort.enable) begin
			memory[writePort.bank][writePort.address] <= writePort.data;
		end
	end

	//////////////////////////////////////////////////
	// Registered read
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (readPort.enable) begin
			readData <= memory[readPort.bank][readPort.address];
		end else begin
			readData <= '0;    // Zero on idle cycles
		end
	end

	assign readPort.data = readData;
	assign fetchInstr = readData;

endmodule

`default_nettype wire

// File: verilog/instrBuffer.sv
// Top level of the double-buffered instruction store
`default_nettype none
`timescale 1ns/100ps

module instrBuffer (
	input wire logic clock,
	input wire logic reset,

	// Host store stream
	input wire logic storeRequest,
	input wire instrBufferPkg::instr_t storeInstr,
	input wire logic storeEnd,

	// Lane fetch side
	input wire logic fetchRequest,
	input wire instrBufferPkg::instrAddress_t fetchAddress,
	input wire logic fetchEnd,
	output instrBufferPkg::instr_t fetchInstr,
	output logic fetchValid,

	// Buffer state
	output logic empty,
	output logic full
);
	import instrBufferPkg::*;

	logic commit;
	logic bankRelease;
	bankIndex_t writeBank;
	bankIndex_t readBank;

	memWritePort writePort ();
	memReadPort readPort ();

	//////////////////////////////////////////////////
	// Bank pointers and occupancy
	//////////////////////////////////////////////////
	bankRing i_bankRing (
		.clock(clock),
		.reset(reset),
		.commit(commit),
		.bankRelease(bankRelease),
		.writeBank(writeBank),
		.readBank(readBank),
		.empty(empty),
		.full(full)
	);

	//////////////////////////////////////////////////
	// Controllers
	//////////////////////////////////////////////////
	storeControl i_storeControl (
		.clock(clock),
		.reset(reset),
		.storeRequest(storeRequest),
		.storeEnd(storeEnd),
		.storeInstr(storeInstr),
		.writeBank(writeBank),
		.full(full),
		.commit(commit),
		.writePort(writePort.source)
	);

	fetchControl i_fetchControl (
		.clock(clock),
		.reset(reset),
		.fetchRequest(fetchRequest),
		.fetchAddress(fetchAddress),
		.fetchEnd(fetchEnd),
		.readBank(readBank),
		.empty(empty),
		.bankRelease(bankRelease),
		.fetchValid(fetchValid),
		.readPort(readPort.source)
	);

	// Memory banks
	bankStore i_bankStore (
		.clock(clock),
		.writePort(writePort.sink),
		.readPort(readPort.sink),
		.fetchInstr(fetchInstr)
	);

endmodule

`default_nettype wire

// File: testbench/instrBufferTb.sv
// Directed testbench for the double-buffered instruction store with reference model and watchdog
`default_nettype none
`timescale 1ns/100ps

`include "instrBuffer_macros.svh"

module instrBufferTb;
	import instrBufferPkg::*;

	localparam int clockPeriod = 8;
	localparam int programLength = 16;
	localparam int fetchCount = 12;
	// Six programs, extra strobes, all fetches and resets, with slack
	localparam int operationCount = 6 * (programLength + 1) + 4 + 8 * fetchCount + 10;
	localparam int watchdogTime = (operationCount + 20) * clockPeriod * 2;

	logic clock;
	logic reset;
	logic storeRequest;
	instr_t storeInstr;
	logic storeEnd;
	logic fetchRequest;
	instrAddress_t fetchAddress;
	logic fetchEnd;
	instr_t fetchInstr;
	logic fetchValid;
	logic empty;
	logic full;

	// Reference model state
	instr_t modelMemory [2][`IMEM_DEPTH];
	bankIndex_t committedBanks [$];    // Front is the bank being read
	bankIndex_t modelWriteBank;
	instrAddress_t modelStoreAddress;
	logic modelFilling;
	logic modelReading;
	int unsigned seedValue;

	instrBuffer i_instrBuffer (
		.clock(clock),
		.reset(reset),
		.storeRequest(storeRequest),
		.storeInstr(storeInstr),
		.storeEnd(storeEnd),
		.fetchRequest(fetchRequest),
		.fetchAddress(fetchAddress),
		.fetchEnd(fetchEnd),
		.fetchInstr(fetchInstr),
		.fetchValid(fetchValid),
		.empty(empty),
		.full(full)
	);

	always #(clockPeriod / 2) clock = ~clock;

	initial begin
		#(watchdogTime);
		$display("Watchdog expired before the tests completed");
		$display("Result: FAILED");
		$fatal(1, "Simulation timed out");
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////
	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERROR: %s is 0x%h, expected 0x%h", name, actual, expected);
			$display("Result: FAILED");
			$fatal(1, "Stopping at first mismatch");
		end
	endtask

	task automatic applyReset();
		reset = 1'b1;
		repeat (2) @(negedge clock);
		reset = 1'b0;
		committedBanks.delete();    // Memory contents survive reset
		modelWriteBank = '0;
		modelStoreAddress = '0;
		modelFilling = 1'b0;
		modelReading = 1'b0;
	endtask

	task automatic checkFlags();
		checkValue("empty", 32'(empty), 32'(committedBanks.size() == 0));
		checkValue("full", 32'(full), 32'(committedBanks.size() == 2));
	endtask

	task automatic storeWord(input instr_t word);
		storeRequest = 1'b1;
		storeInstr = word;
		if (committedBanks.size() < 2) begin    // Dropped while full
			modelMemory[modelWriteBank][modelStoreAddress] = word;
			modelStoreAddress = modelStoreAddress + 1'b1;
			modelFilling = 1'b1;
		end
		@(negedge clock);
		storeRequest = 1'b0;
	endtask

	task automatic storeWords(input int length);
		for (int i = 0; i < length; i++) begin
			storeWord($urandom);
		end
	endtask

	// Commit bookkeeping shared by the pulse tasks
	task automatic modelCommit();
		if (modelFilling) begin
			committedBanks.push_back(modelWriteBank);
			modelWriteBank = ~modelWriteBank;
			modelStoreAddress = '0;
			modelFilling = 1'b0;
		end
	endtask

	task automatic modelRelease();
		if (modelReading) begin
			void'(committedBanks.pop_front());
			modelReading = 1'b0;
		end
	endtask

	task automatic commitBank();
		storeEnd = 1'b1;
		modelCommit();
		@(negedge clock);
		storeEnd = 1'b0;
	endtask

	task automatic storeProgram(input int length);
		storeWords(length);
		commitBank();
	endtask

	task automatic releaseBank();
		fetchEnd = 1'b1;
		modelRelease();
		@(negedge clock);
		fetchEnd = 1'b0;
	endtask

	task automatic commitAndRelease();
		storeEnd = 1'b1;
		fetchEnd = 1'b1;
		modelRelease();
		modelCommit();
		@(negedge clock);
		storeEnd = 1'b0;
		fetchEnd = 1'b0;
	endtask

	// Request on one edge, result one cycle later
	task automatic fetchCheck(input instrAddress_t address);
		logic expectedValid;
		instr_t expected;
		expectedValid = (committedBanks.size() != 0);
		expected = expectedValid ? modelMemory[committedBanks[0]][address] : '0;
		fetchRequest = 1'b1;
		fetchAddress = address;
		if (expectedValid) begin
			modelReading = 1'b1;
		end
		@(negedge clock);
		fetchRequest = 1'b0;
		checkValue("fetchValid", 32'(fetchValid), 32'(expectedValid));
		checkValue("fetchInstr", fetchInstr, expected);
	endtask

	task automatic fetchRandom(input int count, input int length);
		for (int i = 0; i < count; i++) begin
			fetchCheck(instrAddress_t'($urandom % length));
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////
	task automatic testResetState();
		checkValue("empty", 32'(empty), 32'd1);
		checkValue("full", 32'(full), 32'd0);
		checkValue("fetchValid", 32'(fetchValid), 32'd0);
		checkValue("fetchInstr", fetchInstr, 32'd0);
	endtask

	task automatic testSingleProgram();
		storeProgram(programLength);
		checkFlags();
		fetchRandom(fetchCount, programLength);
		releaseBank();
		checkFlags();
	endtask

	task automatic testDoubleBuffer();
		storeProgram(programLength);
		storeProgram(programLength);
		checkFlags();
		repeat (4) storeWord($urandom);    // Must not reach either bank
		checkFlags();
		fetchRandom(fetchCount, programLength);
		releaseBank();
		checkFlags();
		fetchRandom(fetchCount, programLength);
		releaseBank();
		checkFlags();
	endtask

	task automatic testFetchWhileEmpty();
		checkFlags();
		fetchRandom(4, programLength);
		releaseBank();
		checkFlags();
	endtask

	task automatic testIgnoredCommit();
		applyReset();
		commitBank();
		checkFlags();
		storeProgram(programLength);
		checkFlags();
		fetchCheck('0);    // First word of bank zero
		fetchRandom(fetchCount, programLength);
		releaseBank();
		checkFlags();
	endtask

	task automatic testCommitWithRelease();
		applyReset();
		storeProgram(programLength);
		fetchRandom(4, programLength);
		storeWords(programLength);
		checkFlags();
		commitAndRelease();
		checkFlags();
		fetchRandom(fetchCount, programLength);
		releaseBank();
		checkFlags();
	endtask

	initial begin
		seedValue = $urandom(32'h4abf8394);
		clock = 1'b0;
		reset = 1'b1;
		storeRequest = 1'b0;
		storeInstr = '0;
		storeEnd = 1'b0;
		fetchRequest = 1'b0;
		fetchAddress = '0;
		fetchEnd = 1'b0;
		applyReset();

		testResetState();
		testSingleProgram();
		testDoubleBuffer();
		testFetchWhileEmpty();
		testIgnoredCommit();
		testCommitWithRelease();

		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+verilog
verilog/instrBufferPkg.sv
verilog/memPorts.sv
verilog/bankRing.sv
verilog/storeControl.sv
verilog/fetchControl.sv
verilog/bankStore.sv
verilog/instrBuffer.sv
testbench/instrBufferTb.sv

// File: runSim.sh
#!/bin/sh
# Compile and run the instruction buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f sources.f --top-module instrBufferTb -o simInstrBuffer \
	&& ./obj_dir/simInstrBuffer > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -qx "Result: PASSED" sim.log \
	&& echo "Simulation run succeeded" \
	|| { echo "Simulation run did not pass"; exit 1; }
